//--- verilog/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        st_reset,
        st_fetch,
        st_and,
        st_add,
        st_add_wb,
        st_overflow
    } cu_state_t;

    typedef enum logic [2:0] {
        alu_nop = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3
    } alu_op_t;

    typedef logic [2:0] sel_t;     // datapath mux select

    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_AND = 6'h24;

    // index of the final step in each multi-step sequence
    localparam int unsigned FETCH_LAST = 10;
    localparam int unsigned AND_LAST   = 3;
    localparam int unsigned OVF_LAST   = 5;

    localparam sel_t SEL_REG_RD      = 3'd2;
    localparam sel_t SEL_REG_SP      = 3'd4;   // stack pointer register
    localparam sel_t SEL_WB_ALU      = 3'd1;
    localparam sel_t SEL_WB_SP_INIT  = 3'd7;   // initial sp value
    localparam sel_t SEL_B_FOUR      = 3'd1;
    localparam sel_t SEL_B_OFFSET    = 3'd3;
    localparam sel_t SEL_A_REG       = 3'd1;
    localparam sel_t SEL_PC_EXC      = 3'd2;
    localparam sel_t SEL_ADDR_ALU    = 3'd1;
    localparam sel_t SEL_ADDR_VECTOR = 3'd4;   // exception vector address

endpackage

`default_nettype wire

//--- verilog/step_counter.sv
`timescale 1ns/1ns
`default_nettype none

// counts the steps inside the current sequence
module step_counter #(
    parameter int unsigned STEP_W = 4
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               step_clr,
    output logic [STEP_W-1:0] step
);

    always_ff @(posedge clk) begin
        if (reset || step_clr) begin
            step <= '0;              // every sequence restarts at step 0
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm #(
    parameter int unsigned STEP_W = 4
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire [STEP_W-1:0]    step,
    input  wire [5:0]           opcode,
    input  wire [5:0]           funct,
    input  wire                 overflow,
    output ctrl_pkg::cu_state_t state,
    output logic                step_clr
);

    import ctrl_pkg::*;

    cu_state_t next_state;

    // last step of the running sequence
    always_comb begin
        case (state)
            st_reset,
            st_add,
            st_add_wb:   step_clr = (step == '0);          // single cycle states
            st_fetch:    step_clr = (step == STEP_W'(FETCH_LAST));
            st_and:      step_clr = (step == STEP_W'(AND_LAST));
            st_overflow: step_clr = (step == STEP_W'(OVF_LAST));
            default:     step_clr = 1'b1;
        endcase
    end

    // state only moves when a sequence ends
    always_comb begin
        next_state = state;
        if (step_clr) begin
            case (state)
                st_fetch: begin
                    if (opcode == OP_RTYPE && funct == FUNCT_AND) begin
                        next_state = st_and;
                    end else if (opcode == OP_RTYPE && funct == FUNCT_ADD) begin
                        next_state = st_add;
                    end else begin
                        next_state = st_fetch;     // anything else is a no-op
                    end
                end
                st_add: begin
                    next_state = overflow ? st_overflow : st_add_wb;
                end
                default: begin
                    next_state = st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- verilog/control_decode.sv
`timescale 1ns/1ns
`default_nettype none

// moore decode of state and step into the datapath control word
module control_decode #(
    parameter int unsigned STEP_W = 4
) (
    input  wire ctrl_pkg::cu_state_t state,
    input  wire [STEP_W-1:0]         step,
    output logic                     pc_w,
    output logic                     ir_w,
    output logic                     a_w,
    output logic                     b_w,
    output logic                     alu_out_w,
    output logic                     reg_w,
    output logic                     epc_w,
    output logic                     reset_out,
    output ctrl_pkg::alu_op_t        alu_op,
    output ctrl_pkg::sel_t           pc_src,
    output ctrl_pkg::sel_t           reg_dst,
    output ctrl_pkg::sel_t           mem_to_reg,
    output ctrl_pkg::sel_t           alu_src_a,
    output ctrl_pkg::sel_t           alu_src_b,
    output ctrl_pkg::sel_t           iord
);

    import ctrl_pkg::*;

    always_comb begin
        pc_w       = 1'b0;
        ir_w       = 1'b0;
        a_w        = 1'b0;
        b_w        = 1'b0;
        alu_out_w  = 1'b0;
        reg_w      = 1'b0;
        epc_w      = 1'b0;
        reset_out  = 1'b0;
        alu_op     = alu_nop;
        pc_src     = '0;
        reg_dst    = '0;
        mem_to_reg = '0;
        alu_src_a  = '0;
        alu_src_b  = '0;
        iord       = '0;

        case (state)
            st_reset: begin
                reset_out  = 1'b1;
                reg_w      = 1'b1;
                reg_dst    = SEL_REG_SP;
                mem_to_reg = SEL_WB_SP_INIT;    // load sp with its start value
            end
            st_fetch: begin
                case (step)
                    STEP_W'(0), STEP_W'(1), STEP_W'(2): begin
                        alu_op    = alu_add;    // pc + 4
                        alu_src_b = SEL_B_FOUR;
                    end
                    STEP_W'(3): begin
                        alu_op    = alu_add;
                        alu_src_b = SEL_B_FOUR;
                        alu_out_w = 1'b1;
                    end
                    STEP_W'(4): begin
                        alu_op    = alu_add;
                        alu_src_b = SEL_B_FOUR;
                        iord      = SEL_ADDR_ALU;
                    end
                    STEP_W'(5): begin
                        alu_op    = alu_add;
                        alu_src_b = SEL_B_FOUR;
                        iord      = SEL_ADDR_ALU;
                        pc_w      = 1'b1;
                        ir_w      = 1'b1;
                        a_w       = 1'b1;
                        b_w       = 1'b1;
                    end
                    STEP_W'(6), STEP_W'(7), STEP_W'(8): begin
                        alu_op    = alu_add;    // branch target precompute
                        alu_src_b = SEL_B_OFFSET;
                        iord      = SEL_ADDR_ALU;
                        alu_out_w = 1'b1;
                    end
                    STEP_W'(9): begin
                        alu_op    = alu_add;
                        alu_src_b = SEL_B_OFFSET;
                        iord      = SEL_ADDR_ALU;
                    end
                    default: ;                  // decode slot stays quiet
                endcase
            end
            st_and: begin
                if (step == STEP_W'(AND_LAST)) begin
                    reg_w      = 1'b1;
                    reg_dst    = SEL_REG_RD;
                    mem_to_reg = SEL_WB_ALU;
                end else begin
                    alu_op     = alu_and;
                    alu_src_a  = SEL_A_REG;
                    alu_out_w  = 1'b1;
                end
            end
            st_add: begin
                alu_op    = alu_add;
                alu_src_a = SEL_A_REG;
                alu_out_w = 1'b1;
            end
            st_add_wb: begin
                reg_w      = 1'b1;              // same write-back as and
                reg_dst    = SEL_REG_RD;
                mem_to_reg = SEL_WB_ALU;
            end
            st_overflow: begin
                case (step)
                    STEP_W'(0): begin
                        alu_op    = alu_sub;    // back to the faulting pc
                        alu_src_b = SEL_B_FOUR;
                        alu_out_w = 1'b1;
                    end
                    STEP_W'(1): epc_w = 1'b1;
                    STEP_W'(2), STEP_W'(3), STEP_W'(4): begin
                        pc_w   = 1'b1;
                        pc_src = SEL_PC_EXC;
                    end
                    STEP_W'(5): iord = SEL_ADDR_VECTOR;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ctrl_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_unit #(
    parameter int unsigned STEP_W = 4
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                overflow,
    input  wire [5:0]          opcode,
    input  wire [5:0]          funct,
    output logic               pc_w,
    output logic               ir_w,
    output logic               a_w,
    output logic               b_w,
    output logic               alu_out_w,
    output logic               reg_w,
    output logic               epc_w,
    output logic               reset_out,
    output ctrl_pkg::alu_op_t  alu_op,
    output ctrl_pkg::sel_t     pc_src,
    output ctrl_pkg::sel_t     reg_dst,
    output ctrl_pkg::sel_t     mem_to_reg,
    output ctrl_pkg::sel_t     alu_src_a,
    output ctrl_pkg::sel_t     alu_src_b,
    output ctrl_pkg::sel_t     iord
);

    import ctrl_pkg::*;

    logic [STEP_W-1:0] step;
    logic              step_clr;
    cu_state_t         state;

    step_counter #(.STEP_W(STEP_W)) u_step_counter (
        .clk      (clk),
        .reset    (reset),
        .step_clr (step_clr),
        .step     (step)
    );

    control_fsm #(.STEP_W(STEP_W)) u_control_fsm (
        .clk      (clk),
        .reset    (reset),
        .step     (step),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .state    (state),
        .step_clr (step_clr)
    );

    // control word follows state and step directly
    control_decode #(.STEP_W(STEP_W)) u_control_decode (
        .state      (state),
        .step       (step),
        .pc_w       (pc_w),
        .ir_w       (ir_w),
        .a_w        (a_w),
        .b_w        (b_w),
        .alu_out_w  (alu_out_w),
        .reg_w      (reg_w),
        .epc_w      (epc_w),
        .reset_out  (reset_out),
        .alu_op     (alu_op),
        .pc_src     (pc_src),
        .reg_dst    (reg_dst),
        .mem_to_reg (mem_to_reg),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .iord       (iord)
    );

endmodule

`default_nettype wire

//--- verification/tb_ctrl_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ctrl_unit;

    import ctrl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int N_INSTR      = 40;
    localparam int WATCHDOG_NS  = N_INSTR * 22 * CLK_PERIOD + (RESET_CYCLES + 50) * CLK_PERIOD;

    localparam int KIND_AND = 0;
    localparam int KIND_ADD = 1;
    localparam int KIND_NOP = 2;

    logic       clk;
    logic       reset;
    logic       overflow;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       pc_w, ir_w, a_w, b_w, alu_out_w, reg_w, epc_w, reset_out;
    alu_op_t    alu_op;
    sel_t       pc_src, reg_dst, mem_to_reg, alu_src_a, alu_src_b, iord;

    int          seed = 70;
    int          errors = 0;
    logic        started = 1'b0;
    int          instr_kind;
    logic        instr_ovf;
    cu_state_t   m_phase;          // sequence the model expects
    int          m_step;
    logic [44:0] exp_word;
    logic [44:0] got_word;

    // one 3 bit field per output with iord in field 0
    string field_names [15] = '{"iord", "alu_src_b", "alu_src_a", "mem_to_reg", "reg_dst",
                                "pc_src", "alu_op", "reset_out", "epc_w", "reg_w",
                                "alu_out_w", "b_w", "a_w", "ir_w", "pc_w"};

    ctrl_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int seq_cycles(cu_state_t ph);
        case (ph)
            st_fetch:    return 11;
            st_and:      return 4;
            st_overflow: return 6;
            default:     return 1;
        endcase
    endfunction

    function automatic logic [44:0] expected_word(cu_state_t ph, int st);
        logic [7:0] s;     // pc_w ir_w a_w b_w alu_out_w reg_w epc_w reset_out
        alu_op_t    op;
        sel_t       pcs, dst, wb, sa, sb, ad;
        s   = '0;
        op  = alu_nop;
        pcs = '0;
        dst = '0;
        wb  = '0;
        sa  = '0;
        sb  = '0;
        ad  = '0;
        case (ph)
            st_reset: begin
                s   = 8'b0000_0101;
                dst = SEL_REG_SP;
                wb  = SEL_WB_SP_INIT;
            end
            st_fetch: begin
                if (st <= 9) begin
                    op = alu_add;
                    sb = (st >= 6) ? SEL_B_OFFSET : SEL_B_FOUR;
                    ad = (st >= 4) ? SEL_ADDR_ALU : 3'd0;
                end
                if (st == 3 || (st >= 6 && st <= 8)) begin
                    s[3] = 1'b1;
                end
                if (st == 5) begin
                    s[7:4] = 4'hf;             // pc, ir, a and b together
                end
            end
            st_and, st_add: begin
                if (ph == st_and && st == 3) begin
                    s[2] = 1'b1;
                    dst  = SEL_REG_RD;
                    wb   = SEL_WB_ALU;
                end else begin
                    s[3] = 1'b1;
                    op   = (ph == st_and) ? alu_and : alu_add;
                    sa   = SEL_A_REG;
                end
            end
            st_add_wb: begin
                s[2] = 1'b1;
                dst  = SEL_REG_RD;
                wb   = SEL_WB_ALU;
            end
            st_overflow: begin
                if (st == 0) begin
                    s[3] = 1'b1;
                    op   = alu_sub;
                    sb   = SEL_B_FOUR;
                end else if (st == 1) begin
                    s[1] = 1'b1;               // epc once
                end else if (st <= 4) begin
                    s[7] = 1'b1;
                    pcs  = SEL_PC_EXC;
                end else begin
                    ad = SEL_ADDR_VECTOR;
                end
            end
            default: ;
        endcase
        return {3'(s[7]), 3'(s[6]), 3'(s[5]), 3'(s[4]), 3'(s[3]), 3'(s[2]), 3'(s[1]),
                3'(s[0]), op, pcs, dst, wb, sa, sb, ad};
    endfunction

    // sequence timeline from the cycle counts and the driven instruction
    always @(posedge clk) begin
        started <= 1'b1;
        if (reset) begin
            m_phase <= st_reset;
            m_step  <= 0;
        end else if (m_step < seq_cycles(m_phase) - 1) begin
            m_step <= m_step + 1;
        end else begin
            m_step <= 0;
            case (m_phase)
                st_fetch: m_phase <= (instr_kind == KIND_AND) ? st_and :
                                     (instr_kind == KIND_ADD) ? st_add : st_fetch;
                st_add:   m_phase <= instr_ovf ? st_overflow : st_add_wb;
                default:  m_phase <= st_fetch;
            endcase
        end
    end

    always_comb exp_word = expected_word(m_phase, m_step);

    assign got_word = {3'(pc_w), 3'(ir_w), 3'(a_w), 3'(b_w), 3'(alu_out_w), 3'(reg_w),
                       3'(epc_w), 3'(reset_out), alu_op, pc_src, reg_dst, mem_to_reg,
                       alu_src_a, alu_src_b, iord};

    task automatic report_mismatch(input logic [44:0] exp_w, input logic [44:0] got_w);
        for (int i = 0; i < 15; i++) begin
            if (got_w[3*i +: 3] !== exp_w[3*i +: 3]) begin
                $display("FAIL %s expected %h got %h at %0t ns", field_names[i],
                         exp_w[3*i +: 3], got_w[3*i +: 3], $time);
            end
        end
        errors++;
    endtask

    assert property (@(posedge clk) started |-> got_word == exp_word)
        else report_mismatch($sampled(exp_word), $sampled(got_word));

    assert property (@(posedge clk) started && reset |-> reset_out)
        else begin
            $display("FAIL reset_out expected 1 got %h at %0t ns", $sampled(reset_out), $time);
            errors++;
        end

    // a fetch pc write also loads ir, a and b
    assert property (@(posedge clk) started && pc_w && pc_src != SEL_PC_EXC |-> ir_w && a_w && b_w)
        else begin
            $display("fetch pc_w came without ir_w, a_w and b_w at %0t ns", $time);
            errors++;
        end

    task automatic wait_fetch_pc();
        do
            @(negedge clk);
        while (!(pc_w && ir_w));
    endtask

    task automatic drive_instr();
        logic [31:0] r;
        r = $random(seed);
        instr_kind = int'(r[7:0]) % 3;
        instr_ovf  = r[8];
        overflow   = r[8];                 // ignored unless add
        opcode     = OP_RTYPE;
        case (instr_kind)
            KIND_AND: funct = FUNCT_AND;
            KIND_ADD: funct = FUNCT_ADD;
            default: begin
                if (r[9]) begin
                    opcode = r[15:10] | 6'h01;
                    funct  = r[16] ? FUNCT_ADD : FUNCT_AND;
                end else begin
                    funct = {1'b0, r[21:17]};  // never 0x20 or 0x24
                end
            end
        endcase
    endtask

    initial begin
        reset      = 1'b1;
        overflow   = 1'b0;
        opcode     = 6'h3f;
        funct      = 6'h00;
        instr_kind = KIND_NOP;
        instr_ovf  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < N_INSTR; n++) begin
            wait_fetch_pc();
            @(negedge clk);
            drive_instr();
        end
        wait_fetch_pc();                   // last instruction retired
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d", errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ctrl_unit.f
verilog/ctrl_pkg.sv
verilog/step_counter.sv
verilog/control_fsm.sv
verilog/control_decode.sv
verilog/ctrl_unit.sv
verification/tb_ctrl_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ctrl_unit
FLAGS     ?= --binary --timing --assert
FILELIST  ?= ctrl_unit.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
